//--- layer_pkg.sv
`default_nettype none

package layer_pkg;

   // data word width shared by inputs, coefficients and results
   localparam int word_w = 16;

   // all arithmetic wraps to this width
   typedef logic signed [word_w-1:0] word_t;

   // per-cycle command broadcast to every lane
   typedef struct packed {
      logic clear;
      logic mac;
      logic capture;
   } lane_cmd_t;

   // controller states
   typedef enum logic [2:0] {
      st_idle,
      st_load,
      st_compute,
      st_settle,
      st_drain
   } ctrl_state_t;

endpackage

`default_nettype wire

//--- vector_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module vector_buffer #(
   parameter int N = 4,
   localparam int aw = (N > 1) ? $clog2(N) : 1
) (
   input  logic              clk,
   input  logic              wr_en,
   input  logic [aw-1:0]     addr,
   input  layer_pkg::word_t  data_in,
   output layer_pkg::word_t  x
);
   import layer_pkg::*;

   word_t mem [N];

   // read is registered every cycle, old contents on a same-address write
   always_ff @(posedge clk) begin
      x <= mem[addr];
      if (wr_en) begin
         mem[addr] <= data_in;
      end
   end

endmodule

`default_nettype wire

//--- coef_rom.sv
`timescale 1ns/1ps
`default_nettype none

module coef_rom #(
   parameter int    M = 8,
   parameter int    N = 4,
   parameter int    P = 4,
   parameter string w_file = "weights.hex",
   parameter string b_file = "bias.hex",
   localparam int   aw = (N > 1) ? $clog2(N) : 1,
   localparam int   bw = (M / P > 1) ? $clog2(M / P) : 1
) (
   input  logic                    clk,
   input  logic [aw-1:0]           w_addr,
   input  logic [bw-1:0]           b_addr,
   output layer_pkg::word_t [P-1:0] weights,
   output layer_pkg::word_t [P-1:0] biases
);
   import layer_pkg::*;

   // weights stored neuron-major, N entries per neuron
   word_t w_mem [M*N];
   word_t b_mem [M];

   initial begin
      $readmemh(w_file, w_mem);
      $readmemh(b_file, b_mem);
   end

   // lane p of group b_addr serves neuron b_addr*P + p
   always_ff @(posedge clk) begin
      for (int p = 0; p < P; p++) begin
         weights[p] <= w_mem[(int'(b_addr) * P + p) * N + int'(w_addr)];
         biases[p]  <= b_mem[int'(b_addr) * P + p];
      end
   end

endmodule

`default_nettype wire

//--- mac_lane.sv
`timescale 1ns/1ps
`default_nettype none

module mac_lane (
   input  logic                 clk,
   input  layer_pkg::lane_cmd_t cmd,
   input  layer_pkg::word_t     x,
   input  layer_pkg::word_t     weight,
   input  layer_pkg::word_t     bias,
   output layer_pkg::word_t     result
);
   import layer_pkg::*;

   word_t acc;
   word_t prod;

   // product evaluated at word width, so the upper half is dropped
   assign prod = x * weight;

   always_ff @(posedge clk) begin
      if (cmd.clear) begin
         acc <= bias;
      end else if (cmd.mac) begin
         acc <= acc + prod;
      end
   end

   // relu, held until the next group is captured
   always_ff @(posedge clk) begin
      if (cmd.capture) begin
         result <= (acc > 0) ? acc : '0;
      end
   end

endmodule

`default_nettype wire

//--- layer_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module layer_ctrl #(
   parameter int  M = 8,
   parameter int  N = 4,
   parameter int  P = 4,
   localparam int aw = (N > 1) ? $clog2(N) : 1,
   localparam int bw = (M / P > 1) ? $clog2(M / P) : 1
) (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 s_valid,
   output logic                 s_ready,
   input  logic                 busy,
   output logic                 wr_en,
   output logic [aw-1:0]        addr,
   output logic [aw-1:0]        w_addr,
   output logic [bw-1:0]        b_addr,
   output layer_pkg::lane_cmd_t cmd,
   output logic                 load
);
   import layer_pkg::*;

   localparam int groups = M / P;
   localparam int gw = $clog2(groups + 1);

   ctrl_state_t state;
   ctrl_state_t next_state;
   logic [aw-1:0] in_cnt;
   logic [aw-1:0] mac_idx;
   logic [gw-1:0] grp;
   logic last_in;
   logic last_grp;
   lane_cmd_t cmd_raw;
   logic load_raw;

   // after the last group, idle keeps s_ready low until the serializer empties
   assign s_ready = (state == st_load) || (state == st_idle && !busy);
   assign wr_en = s_valid && s_ready;
   assign last_in = wr_en && (in_cnt == aw'(N - 1));
   assign last_grp = (grp == gw'(groups));

   assign addr = (state == st_compute) ? mac_idx : in_cnt;
   assign w_addr = mac_idx;
   assign b_addr = grp[bw-1:0];

   always_comb begin
      next_state = state;
      cmd_raw = '0;
      load_raw = 1'b0;
      case (state)
         st_idle, st_load: begin
            if (last_in) begin
               next_state = st_compute;
               cmd_raw.clear = 1'b1;
            end else if (wr_en) begin
               next_state = st_load;
            end
         end
         st_compute: begin
            cmd_raw.mac = 1'b1;
            if (mac_idx == aw'(N - 1)) begin
               next_state = st_settle;
            end
         end
         st_settle: begin
            cmd_raw.capture = 1'b1;
            next_state = st_drain;
         end
         st_drain: begin
            // lanes hold their results until the serializer can take them
            if (!busy) begin
               load_raw = 1'b1;
               if (last_grp) begin
                  next_state = st_idle;
               end else begin
                  next_state = st_compute;
                  cmd_raw.clear = 1'b1;
               end
            end
         end
         default: next_state = st_idle;
      endcase
   end

   // cmd and load lag one cycle to meet the registered memory reads
   always_ff @(posedge clk) begin
      if (reset) begin
         state <= st_idle;
         in_cnt <= '0;
         mac_idx <= '0;
         grp <= '0;
         cmd <= '0;
         load <= 1'b0;
      end else begin
         state <= next_state;
         cmd <= cmd_raw;
         load <= load_raw;
         if (last_in) begin
            in_cnt <= '0;
         end else if (wr_en) begin
            in_cnt <= in_cnt + 1'b1;
         end
         if (state == st_compute) begin
            if (mac_idx == aw'(N - 1)) begin
               mac_idx <= '0;
            end else begin
               mac_idx <= mac_idx + 1'b1;
            end
         end
         if (state == st_settle) begin
            grp <= grp + 1'b1;
         end else if (load_raw && last_grp) begin
            grp <= '0;
         end
      end
   end

endmodule

`default_nettype wire

//--- output_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module output_serializer #(
   parameter int  P = 4,
   localparam int pw = (P > 1) ? $clog2(P) : 1
) (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     load,
   input  layer_pkg::word_t [P-1:0] results,
   input  logic                     m_ready,
   output logic                     m_valid,
   output layer_pkg::word_t         data_out,
   output logic                     busy
);
   import layer_pkg::*;

   word_t [P-1:0] held;
   logic [pw-1:0] sel;
   logic last_sent;

   assign last_sent = m_valid && m_ready && (sel == pw'(P - 1));
   assign data_out = held[sel];
   // a load in flight counts as busy so the controller never overruns
   assign busy = m_valid || load;

   always_ff @(posedge clk) begin
      if (load) begin
         held <= results;
      end
   end

   // lane 0 goes out first, sel stalls while m_ready is low
   always_ff @(posedge clk) begin
      if (reset) begin
         m_valid <= 1'b0;
         sel <= '0;
      end else if (load) begin
         m_valid <= 1'b1;
         sel <= '0;
      end else if (last_sent) begin
         m_valid <= 1'b0;
      end else if (m_valid && m_ready) begin
         sel <= sel + 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- fc_layer.sv
`timescale 1ns/1ps
`default_nettype none

module fc_layer #(
   parameter int M = 8,
   parameter int N = 4,
   parameter int P = 4
) (
   input  logic             clk,
   input  logic             reset,
   input  logic             s_valid,
   output logic             s_ready,
   input  layer_pkg::word_t data_in,
   output logic             m_valid,
   input  logic             m_ready,
   output layer_pkg::word_t data_out
);
   import layer_pkg::*;

   localparam int aw = (N > 1) ? $clog2(N) : 1;
   localparam int bw = (M / P > 1) ? $clog2(M / P) : 1;

   logic          wr_en;
   logic          load;
   logic          busy;
   logic [aw-1:0] addr;
   logic [aw-1:0] w_addr;
   logic [bw-1:0] b_addr;
   lane_cmd_t     cmd;
   word_t         x;
   word_t [P-1:0] weights;
   word_t [P-1:0] biases;
   word_t [P-1:0] results;

   vector_buffer #(.N(N)) vector_buffer_i (
      .clk, .wr_en, .addr, .data_in, .x
   );

   coef_rom #(.M(M), .N(N), .P(P)) coef_rom_i (
      .clk, .w_addr, .b_addr, .weights, .biases
   );

   for (genvar p = 0; p < P; p++) begin : g_lane
      mac_lane mac_lane_i (
         .clk,
         .cmd,
         .x,
         .weight (weights[p]),
         .bias   (biases[p]),
         .result (results[p])
      );
   end

   layer_ctrl #(.M(M), .N(N), .P(P)) layer_ctrl_i (
      .clk, .reset, .s_valid, .s_ready, .busy, .wr_en,
      .addr, .w_addr, .b_addr, .cmd, .load
   );

   output_serializer #(.P(P)) output_serializer_i (
      .clk, .reset, .load, .results, .m_ready, .m_valid, .data_out, .busy
   );

endmodule

`default_nettype wire

//--- fc_layer_assert.sv
`timescale 1ns/1ps
`default_nettype none

module fc_layer_assert (
   input logic             clk,
   input logic             reset,
   input logic             s_ready,
   input logic             m_valid,
   input logic             m_ready,
   input layer_pkg::word_t data_out
);

   // a stalled output word stays valid and unchanged
   property stall_hold;
      @(posedge clk) disable iff (reset)
         (m_valid && !m_ready) |=> (m_valid && $stable(data_out));
   endproperty

   // input is closed while results are being sent
   property ready_valid_exclusive;
      @(posedge clk) disable iff (reset)
         !(s_ready && m_valid);
   endproperty

   property quiet_after_reset;
      @(posedge clk) reset |=> !m_valid;
   endproperty

   a_stall_hold: assert property (stall_hold)
      else $error("output word or m_valid changed while m_ready was low");

   a_ready_valid_exclusive: assert property (ready_valid_exclusive)
      else $error("s_ready and m_valid were high in the same cycle");

   a_quiet_after_reset: assert property (quiet_after_reset)
      else $error("m_valid was high in the cycle after reset");

endmodule

`default_nettype wire

//--- tb_fc_layer.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fc_layer;
   import layer_pkg::*;

   localparam int M = 8;
   localparam int N = 4;
   localparam int P = 4;
   localparam int xw = $clog2(N);
   localparam string w_file = "weights.hex";
   localparam string b_file = "bias.hex";
   localparam int num_tests = 6;
   localparam int period_ns = 40;
   // load, every group's compute and every output word, four times over for gaps and stalls
   localparam int test_cycles = N + (M / P) * (N + 2) + M;
   localparam int timeout_ns = (num_tests * test_cycles * 4 + 200) * period_ns;

   typedef struct packed {
      word_t [0:N-1] vec;
      int            gap_pct;
      int            stall_pct;
   } test_t;

   localparam test_t tests [num_tests] = '{
      '{{16'sd1, 16'sd2, 16'sd3, 16'sd4}, 0, 0},
      '{{-16'sd50, 16'sd3, 16'sd40, -16'sd10}, 0, 0},
      '{{16'sd1, 16'sd2, 16'sd3, 16'sd4}, 50, 0},
      '{{-16'sd50, 16'sd3, 16'sd40, -16'sd10}, 0, 50},
      '{{16'h1234, 16'h7fff, 16'h8000, 16'h0fff}, 30, 40},
      '{{16'sd9, -16'sd7, 16'sd100, 16'sd25}, 0, 0}
   };

   string names [num_tests] = '{"positive", "negative", "input_gaps", "output_stalls",
                                "wrap_gaps_stalls", "back_to_back"};

   logic   clk;
   logic   reset;
   logic   s_valid;
   logic   s_ready;
   logic   m_valid;
   logic   m_ready;
   word_t  data_in;
   word_t  data_out;
   word_t  w_ref [M*N];
   word_t  b_ref [M];
   word_t  expected [M];
   integer seed = 32'h8179a53b;

   fc_layer #(.M(M), .N(N), .P(P)) fc_layer_i (
      .clk, .reset, .s_valid, .s_ready, .data_in, .m_valid, .m_ready, .data_out
   );

   bind fc_layer fc_layer_assert fc_layer_assert_i (
      .clk, .reset, .s_ready, .m_valid, .m_ready, .data_out
   );

   always #(period_ns / 2) clk = ~clk;

   function int rand_pct();
      return int'({$random(seed)} % 32'd100);
   endfunction

   task automatic abort_run(string why);
      $display("%s", why);
      $display("Finished with errors");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check_word(string what, word_t exp, word_t act);
      if (act !== exp) begin
         abort_run($sformatf("CHECK FAILED %s: expected %0d actual %0d", what, exp, act));
      end
   endtask

   task automatic check_bit(string what, logic exp, logic act);
      if (act !== exp) begin
         abort_run($sformatf("CHECK FAILED %s: expected %b actual %b", what, exp, act));
      end
   endtask

   // bias plus products, product and sum each cut to one word, then relu
   task automatic model_layer(int t);
      logic signed [31:0] full;
      word_t xi;
      word_t wi;
      word_t acc;
      for (int o = 0; o < M; o++) begin
         acc = b_ref[o];
         for (int i = 0; i < N; i++) begin
            xi = tests[t].vec[i[xw-1:0]];
            wi = w_ref[o * N + i];
            full = 32'(xi) * 32'(wi);
            acc = acc + full[word_w-1:0];
         end
         expected[o] = (acc > word_t'(0)) ? acc : '0;
      end
   endtask

   task automatic run_test(int t);
      int in_idx;
      int out_idx;
      int gap_draw;
      logic inputs_done;
      in_idx = 0;
      out_idx = 0;
      model_layer(t);
      while (out_idx < M) begin
         @(negedge clk);
         gap_draw = rand_pct();
         s_valid = 1'b0;
         if (in_idx < N && gap_draw >= tests[t].gap_pct) begin
            s_valid = 1'b1;
            data_in = tests[t].vec[in_idx[xw-1:0]];
         end
         m_ready = (rand_pct() >= tests[t].stall_pct);
         // these values decide the transfers on the next rising edge
         inputs_done = (in_idx == N);
         if (inputs_done) begin
            check_bit($sformatf("%s s_ready while busy", names[t]), 1'b0, s_ready);
         end
         if (s_valid && s_ready) begin
            in_idx++;
         end
         if (m_valid && m_ready) begin
            check_word($sformatf("%s neuron %0d", names[t], out_idx),
                       expected[out_idx], data_out);
            out_idx++;
         end
         @(posedge clk);
      end
      @(negedge clk);
      s_valid = 1'b0;
      check_bit($sformatf("%s m_valid after last word", names[t]), 1'b0, m_valid);
      check_bit($sformatf("%s s_ready after last word", names[t]), 1'b1, s_ready);
   endtask

   initial begin
      clk = 1'b0;
      reset = 1'b1;
      s_valid = 1'b0;
      m_ready = 1'b0;
      data_in = '0;
      $readmemh(w_file, w_ref);
      $readmemh(b_file, b_ref);
      repeat (8) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      check_bit("s_ready after reset", 1'b1, s_ready);
      check_bit("m_valid after reset", 1'b0, m_valid);
      for (int t = 0; t < num_tests; t++) begin
         run_test(t);
      end
      $display("Finished with no errors");
      $finish;
   end

   initial begin
      #(timeout_ns);
      abort_run("watchdog expired before all tests finished");
   end

endmodule

`default_nettype wire

//--- weights.hex
// one 16-bit weight per line, neuron-major: inputs 0..3 of neuron 0, then neuron 1, ...
0003
0002
FFFF
0001
FFFE
0004
0001
FFFD
0005
FFFB
0002
0002
FFFF
FFFF
FFFF
FFFF
0007
0001
0000
FFFC
0100
FF00
0080
0001
0002
0002
0002
0002
FFF9
0003
FFFE
0006

//--- bias.hex
// one 16-bit bias per line, neuron 0 first
0010
FFF0
0000
0040
FFE0
0008
FF00
0020

//--- flist.f
layer_pkg.sv
vector_buffer.sv
coef_rom.sv
mac_lane.sv
layer_ctrl.sv
output_serializer.sv
fc_layer.sv
fc_layer_assert.sv
tb_fc_layer.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the fc_layer testbench with verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_fc_layer \
   -f flist.f --Mdir obj_dir -o sim_fc_layer
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit $status
fi

./obj_dir/sim_fc_layer
status=$?
if [ $status -ne 0 ]; then
   echo "simulation failed with status $status"
   exit $status
fi

exit 0
